//--- rtl/lsu_defines.svh
/*
 * vector load/store unit sizes
 * register, memory word and vl field widths plus derived beat sizes
 */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// vector register and memory word width in bits
`define LSU_VREG_W 128
`define LSU_VMEM_W 32

// vl holds element counts 0 to 128
`define LSU_VL_W 8

////////////////////
// derived sizes

`define LSU_BEATS_PER_VREG (`LSU_VREG_W / `LSU_VMEM_W)
`define LSU_BEAT_W $clog2(`LSU_BEATS_PER_VREG)
`define LSU_VMSK_W (`LSU_VREG_W / 8)

`endif

//--- rtl/lsu_pkg.sv
/*
 * vector load/store unit types
 * operation, configuration, memory and register file structs
 */
`include "lsu_defines.svh"

package lsu_pkg;

    // element width, the value is log2 of the element size in bytes
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    // registers per group, the value is log2 of the group size
    typedef enum logic [1:0] {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2,
        LMUL_8 = 2'd3
    } lmul_e;

    typedef struct packed {
        logic store;
        eew_e eew;
        logic masked;
    } lsu_op_t;

    typedef struct packed {
        lmul_e                lmul;
        logic [`LSU_VL_W-1:0] vl;
        logic [31:0]          base_addr;
        logic [4:0]           vd;
    } lsu_cfg_t;

    // running count, or register index and word index within it
    typedef union packed {
        logic [`LSU_BEAT_W+2:0] val;
        struct packed {
            logic [2:0]             grp;
            logic [`LSU_BEAT_W-1:0] beat;
        } part;
    } beat_count_u;

    typedef struct packed {
        logic                     req;
        logic [31:0]              addr;
        logic                     we;
        logic [`LSU_VMEM_W/8-1:0] be;
        logic [`LSU_VMEM_W-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   gnt;
        logic                   rvalid;
        logic [`LSU_VMEM_W-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                   en;
        logic [4:0]             addr;
        logic [`LSU_VMSK_W-1:0] mask;
        logic [`LSU_VREG_W-1:0] data;
    } vreg_wr_t;

    // byte enable of one memory word from vl and the v0 element mask
    function automatic logic [`LSU_VMEM_W/8-1:0] lsu_byte_enable(
        input logic [$bits(beat_count_u)-1:0] cnt_val,
        input eew_e                           eew,
        input logic [`LSU_VL_W-1:0]           vl,
        input logic                           masked,
        input logic [`LSU_VREG_W-1:0]         v0
    );
        logic [`LSU_VMEM_W/8-1:0]       be;
        logic [$bits(beat_count_u)+1:0] pos;
        logic [$bits(beat_count_u)+1:0] elem;
        for (int b = 0; b < `LSU_VMEM_W / 8; b++) begin
            // byte position in the group, then the element it belongs to
            pos   = {cnt_val, b[1:0]};
            elem  = pos >> eew;
            be[b] = (elem < vl) && (!masked || v0[elem]);
        end
        return be;
    endfunction

endpackage

//--- rtl/lsu_ctrl.sv
/*
 * load/store operation acceptance
 * latches the operation, starts the beat counters and reports pending work
 */
`timescale 1ns/10ps

module lsu_ctrl (
    input  logic              clk_i,
    input  logic              async_rst_ni,
    input  logic              op_rdy_i,
    input  lsu_pkg::lsu_op_t  op_i,
    input  lsu_pkg::lsu_cfg_t cfg_i,
    input  logic              req_busy_i,
    input  logic              rsp_busy_i,
    output logic              op_ack_o,
    output logic              misaligned_o,
    output logic              start_req_o,
    output logic              start_rsp_o,
    output lsu_pkg::lsu_op_t  op_o,
    output lsu_pkg::lsu_cfg_t cfg_o,
    output logic              pending_load_o,
    output logic              pending_store_o
);

    // run while requests are issued, drain while load data is still due
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   pending;
    logic   accept;

    always_comb begin
        unique case (state_q)
            ST_RUN:   pending = req_busy_i || rsp_busy_i;
            ST_DRAIN: pending = rsp_busy_i;
            default:  pending = 1'b0;
        endcase
    end

    assign op_ack_o     = op_rdy_i && !pending;
    // base address must be word aligned
    assign misaligned_o = op_ack_o && (cfg_i.base_addr[1:0] != 2'b00);
    assign accept       = op_ack_o && !misaligned_o;
    assign start_req_o  = accept;
    assign start_rsp_o  = accept && !op_i.store;

    always_comb begin
        state_d = state_q;
        if (accept) begin
            state_d = ST_RUN;
        end else if (state_q == ST_RUN && !req_busy_i) begin
            state_d = rsp_busy_i ? ST_DRAIN : ST_IDLE;
        end else if (state_q == ST_DRAIN && !rsp_busy_i) begin
            state_d = ST_IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_o  <= op_i;
            cfg_o <= cfg_i;
        end
    end

    assign pending_load_o  = pending && !op_o.store;
    assign pending_store_o = pending && op_o.store;

    // an accepted operation keeps the unit busy and blocks the next one
    a_ack_then_pending: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        op_ack_o && !misaligned_o |=> (pending_load_o || pending_store_o) && !op_ack_o);

endmodule

//--- rtl/lsu_beat_counter.sv
/*
 * beat counter over one register group
 * counts memory words per register and registers per group
 */
`timescale 1ns/10ps

module lsu_beat_counter (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  logic                 start_i,
    input  lsu_pkg::lmul_e       lmul_i,
    input  logic                 advance_i,
    output lsu_pkg::beat_count_u count_o,
    output logic                 busy_o,
    output logic                 last_o
);
    import lsu_pkg::*;

    beat_count_u count_q;
    logic        busy_q;
    logic [2:0]  grp_last;

    // index of the last register in the group
    assign grp_last = 3'((4'd1 << lmul_i) - 4'd1);

    assign last_o  = (count_q.part.beat == '1) && (count_q.part.grp == grp_last);
    assign count_o = count_q;
    assign busy_o  = busy_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            count_q <= '0;
            busy_q  <= 1'b0;
        end else if (start_i) begin
            count_q <= '0;
            busy_q  <= 1'b1;
        end else if (advance_i) begin
            count_q.val <= count_q.val + 1'b1;
            if (last_o) begin
                busy_q <= 1'b0;
            end
        end
    end

    // grants and responses only arrive for a running group
    a_advance_busy: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        advance_i |-> busy_q && !start_i);

endmodule

//--- rtl/lsu_req_path.sv
/*
 * memory request path
 * fetches store data from the register file and drives address, byte enable and data
 */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_req_path (
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  lsu_pkg::lsu_op_t       op_i,
    input  lsu_pkg::lsu_cfg_t      cfg_i,
    input  lsu_pkg::beat_count_u   req_count_i,
    input  logic                   req_busy_i,
    input  logic [`LSU_VREG_W-1:0] v0_i,
    input  logic [`LSU_VREG_W-1:0] vreg_rd_i,
    output logic [4:0]             vreg_rd_addr_o,
    input  lsu_pkg::mem_rsp_t      mem_rsp_i,
    output lsu_pkg::mem_req_t      mem_req_o,
    output logic                   req_adv_o
);
    import lsu_pkg::*;

    logic [`LSU_VREG_W-1:0] vs3_q;
    logic                   vs3_valid_q;
    logic                   fetch;
    logic                   last_beat;

    ////////////////////
    // store data fetch

    // a store reads its next source register before that register's first beat
    assign fetch          = req_busy_i && op_i.store && !vs3_valid_q;
    assign vreg_rd_addr_o = cfg_i.vd + 5'(req_count_i.part.grp);
    assign last_beat      = int'(req_count_i.part.beat) == `LSU_BEATS_PER_VREG - 1;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            vs3_valid_q <= 1'b0;
        end else if (fetch) begin
            vs3_valid_q <= 1'b1;
        end else if (req_adv_o && last_beat) begin
            vs3_valid_q <= 1'b0;
        end
    end

    // one memory word leaves per granted store beat
    always_ff @(posedge clk_i) begin
        if (fetch) begin
            vs3_q <= vreg_rd_i;
        end else if (req_adv_o && op_i.store) begin
            vs3_q <= vs3_q >> `LSU_VMEM_W;
        end
    end

    ////////////////////
    // memory request

    always_comb begin
        mem_req_o.req   = req_busy_i && !fetch;
        mem_req_o.addr  = cfg_i.base_addr + 32'(req_count_i.val) * (`LSU_VMEM_W / 8);
        mem_req_o.we    = op_i.store;
        // loads fetch whole words, disabled bytes are dropped at write-back
        mem_req_o.be    = op_i.store ?
            lsu_byte_enable(req_count_i.val, op_i.eew, cfg_i.vl, op_i.masked, v0_i) : '1;
        mem_req_o.wdata = vs3_q[`LSU_VMEM_W-1:0];
    end

    assign req_adv_o = mem_req_o.req && mem_rsp_i.gnt;

    // memory sees an unchanged request until it grants
    a_req_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        mem_req_o.req && !mem_rsp_i.gnt |=> mem_req_o.req && $stable(mem_req_o));

endmodule

//--- rtl/lsu_load_path.sv
/*
 * load write-back path
 * collects returned words into a register and writes it with its byte mask
 */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_load_path (
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  lsu_pkg::lsu_op_t       op_i,
    input  lsu_pkg::lsu_cfg_t      cfg_i,
    input  lsu_pkg::beat_count_u   rsp_count_i,
    input  logic [`LSU_VREG_W-1:0] v0_i,
    input  lsu_pkg::mem_rsp_t      mem_rsp_i,
    output lsu_pkg::vreg_wr_t      vreg_wr_o
);
    import lsu_pkg::*;

    logic [`LSU_VREG_W-1:0]   data_q;
    logic [`LSU_VMSK_W-1:0]   mask_q;
    logic [`LSU_VMEM_W/8-1:0] word_be;
    logic                     reg_done;
    logic                     wr_en_q;
    logic [4:0]               wr_addr_q;

    // unit stride, so the mask is recomputed from the response count
    assign word_be = lsu_byte_enable(rsp_count_i.val, op_i.eew, cfg_i.vl, op_i.masked, v0_i);

    // last word of a register has arrived
    assign reg_done = mem_rsp_i.rvalid &&
                      (int'(rsp_count_i.part.beat) == `LSU_BEATS_PER_VREG - 1);

    ////////////////////
    // word assembly

    // words enter at the top, the first word ends up in the low bits
    always_ff @(posedge clk_i) begin
        if (mem_rsp_i.rvalid) begin
            data_q <= {mem_rsp_i.rdata, data_q[`LSU_VREG_W-1:`LSU_VMEM_W]};
            mask_q <= {word_be, mask_q[`LSU_VMSK_W-1:`LSU_VMEM_W/8]};
        end
        if (reg_done) begin
            wr_addr_q <= cfg_i.vd + 5'(rsp_count_i.part.grp);
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= reg_done;
        end
    end

    ////////////////////
    // register write-back

    always_comb begin
        vreg_wr_o.en   = wr_en_q;
        vreg_wr_o.addr = wr_addr_q;
        vreg_wr_o.mask = mask_q;
        vreg_wr_o.data = data_q;
    end

    // read data only comes back for the load latched by the controller
    a_rvalid_load: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        mem_rsp_i.rvalid |-> !op_i.store);

endmodule

//--- rtl/lsu_top.sv
/*
 * unit-stride vector load/store unit
 * moves one register group between the register file and a 32-bit memory
 */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_top (
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  logic                   op_rdy_i,
    input  lsu_pkg::lsu_op_t       op_i,
    input  lsu_pkg::lsu_cfg_t      cfg_i,
    output logic                   op_ack_o,
    output logic                   misaligned_o,
    output logic                   pending_load_o,
    output logic                   pending_store_o,
    input  logic [`LSU_VREG_W-1:0] v0_i,
    input  logic [`LSU_VREG_W-1:0] vreg_rd_i,
    output logic [4:0]             vreg_rd_addr_o,
    output lsu_pkg::vreg_wr_t      vreg_wr_o,
    output lsu_pkg::mem_req_t      mem_req_o,
    input  lsu_pkg::mem_rsp_t      mem_rsp_i
);
    import lsu_pkg::*;

    lsu_op_t     op_q;
    lsu_cfg_t    cfg_q;
    logic        start_req;
    logic        start_rsp;
    logic        req_busy;
    logic        rsp_busy;
    logic        req_adv;
    beat_count_u req_count;
    beat_count_u rsp_count;

    lsu_ctrl u_ctrl (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .op_rdy_i        (op_rdy_i),
        .op_i            (op_i),
        .cfg_i           (cfg_i),
        .req_busy_i      (req_busy),
        .rsp_busy_i      (rsp_busy),
        .op_ack_o        (op_ack_o),
        .misaligned_o    (misaligned_o),
        .start_req_o     (start_req),
        .start_rsp_o     (start_rsp),
        .op_o            (op_q),
        .cfg_o           (cfg_q),
        .pending_load_o  (pending_load_o),
        .pending_store_o (pending_store_o)
    );

    // request side steps on grants
    lsu_beat_counter u_req_cnt (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .start_i      (start_req),
        .lmul_i       (cfg_q.lmul),
        .advance_i    (req_adv),
        .count_o      (req_count),
        .busy_o       (req_busy),
        .last_o       ()
    );

    // response side steps on returned load data
    lsu_beat_counter u_rsp_cnt (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .start_i      (start_rsp),
        .lmul_i       (cfg_q.lmul),
        .advance_i    (mem_rsp_i.rvalid),
        .count_o      (rsp_count),
        .busy_o       (rsp_busy),
        .last_o       ()
    );

    lsu_req_path u_req_path (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_i           (op_q),
        .cfg_i          (cfg_q),
        .req_count_i    (req_count),
        .req_busy_i     (req_busy),
        .v0_i           (v0_i),
        .vreg_rd_i      (vreg_rd_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .mem_rsp_i      (mem_rsp_i),
        .mem_req_o      (mem_req_o),
        .req_adv_o      (req_adv)
    );

    lsu_load_path u_load_path (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_i         (op_q),
        .cfg_i        (cfg_q),
        .rsp_count_i  (rsp_count),
        .v0_i         (v0_i),
        .mem_rsp_i    (mem_rsp_i),
        .vreg_wr_o    (vreg_wr_o)
    );

endmodule

//--- verif/tb_lsu_env.sv
/*
 * load/store unit test environment
 * memory with random grant and response delays, and the vector register file
 */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module tb_lsu_env (
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  lsu_pkg::mem_req_t      mem_req_i,
    output lsu_pkg::mem_rsp_t      mem_rsp_o,
    input  logic [4:0]             vreg_rd_addr_i,
    output logic [`LSU_VREG_W-1:0] vreg_rd_o,
    input  lsu_pkg::vreg_wr_t      vreg_wr_i
);
    import lsu_pkg::*;

    logic [7:0]             mem [256];
    logic [`LSU_VREG_W-1:0] rf [32];

    logic [1:0]  gnt_wait_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        gnt;
    int          cyc;
    int          last_due;
    int          due_q[$];
    logic [31:0] word_q[$];

    // grant once the random wait has run out
    assign gnt       = mem_req_i.req && (gnt_wait_q == 2'd0);
    assign mem_rsp_o = {gnt, rvalid_q, rdata_q};
    assign vreg_rd_o = rf[vreg_rd_addr_i];

    task automatic init_mem();
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'($urandom);
        end
    endtask

    task automatic init_rf();
        for (int r = 0; r < 32; r++) begin
            for (int b = 0; b < `LSU_VMSK_W; b++) begin
                rf[r][b*8 +: 8] = 8'(r * 16 + b) ^ 8'h5a;
            end
        end
    endtask

    ////////////////////
    // memory

    always @(posedge clk_i or negedge async_rst_ni) begin
        int          due;
        logic [31:0] word;
        if (!async_rst_ni) begin
            gnt_wait_q <= 2'd0;
            rvalid_q   <= 1'b0;
            rdata_q    <= '0;
            cyc = 0;
            last_due = 0;
            due_q.delete();
            word_q.delete();
        end else begin
            cyc = cyc + 1;
            if (mem_req_i.req && !gnt) begin
                gnt_wait_q <= gnt_wait_q - 2'd1;
            end
            if (mem_req_i.req && gnt) begin
                gnt_wait_q <= 2'($urandom_range(2, 0));
                for (int b = 0; b < 4; b++) begin
                    if (mem_req_i.we && mem_req_i.be[b]) begin
                        mem[8'(mem_req_i.addr[7:0] + b)] = mem_req_i.wdata[b*8 +: 8];
                    end
                    word[b*8 +: 8] = mem[8'(mem_req_i.addr[7:0] + b)];
                end
                if (!mem_req_i.we) begin
                    // responses stay in order, one per cycle at most
                    due = cyc + int'($urandom_range(3, 1));
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    due_q.push_back(due);
                    word_q.push_back(word);
                end
            end
            rvalid_q <= 1'b0;
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                rvalid_q <= 1'b1;
                rdata_q  <= word_q.pop_front();
                void'(due_q.pop_front());
            end
        end
    end

    ////////////////////
    // register file write with byte mask

    always @(posedge clk_i) begin
        if (vreg_wr_i.en) begin
            for (int b = 0; b < `LSU_VMSK_W; b++) begin
                if (vreg_wr_i.mask[b]) begin
                    rf[vreg_wr_i.addr][b*8 +: 8] = vreg_wr_i.data[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- verif/tb_lsu_top.sv
/*
 * load/store unit testbench
 * applies an operation table and checks memory, registers and flags
 */
`timescale 1ns/10ps
`include "lsu_defines.svh"

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int NUM_ROWS   = 12;
    localparam int CLK_PERIOD = 8;
    localparam int TIMEOUT    = NUM_ROWS * 8 * 4 * 6 + 200;

    typedef struct packed {
        lsu_op_t                op;
        lmul_e                  lmul;
        logic [`LSU_VL_W-1:0]   vl;
        logic [31:0]            base;
        logic [4:0]             vd;
        logic [`LSU_VREG_W-1:0] v0;
        logic                   misaligned;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   op_rdy;
    lsu_op_t                op;
    lsu_cfg_t               cfg;
    logic [`LSU_VREG_W-1:0] v0;
    logic [`LSU_VREG_W-1:0] vreg_rd;
    logic [4:0]             vreg_rd_addr;
    vreg_wr_t               vreg_wr;
    mem_req_t               mem_req;
    mem_rsp_t               mem_rsp;
    logic                   op_ack;
    logic                   misaligned;
    logic                   pending_load;
    logic                   pending_store;

    row_t                   rows [NUM_ROWS];
    logic [7:0]             exp_mem [256];
    logic [`LSU_VREG_W-1:0] exp_rf [32];
    int                     wr_pulses;
    int                     req_cycles;
    int                     cycles;

    lsu_top DUT (
        .clk_i           (clk),
        .async_rst_ni    (rst_n),
        .op_rdy_i        (op_rdy),
        .op_i            (op),
        .cfg_i           (cfg),
        .op_ack_o        (op_ack),
        .misaligned_o    (misaligned),
        .pending_load_o  (pending_load),
        .pending_store_o (pending_store),
        .v0_i            (v0),
        .vreg_rd_i       (vreg_rd),
        .vreg_rd_addr_o  (vreg_rd_addr),
        .vreg_wr_o       (vreg_wr),
        .mem_req_o       (mem_req),
        .mem_rsp_i       (mem_rsp)
    );

    tb_lsu_env env (
        .clk_i          (clk),
        .async_rst_ni   (rst_n),
        .mem_req_i      (mem_req),
        .mem_rsp_o      (mem_rsp),
        .vreg_rd_addr_i (vreg_rd_addr),
        .vreg_rd_o      (vreg_rd),
        .vreg_wr_i      (vreg_wr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopping on first error");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            report_failure($sformatf("timeout, no end of test after %0d cycles", TIMEOUT));
        end
    end

    // write pulses and request cycles, sampled mid-cycle
    always @(negedge clk) begin
        if (vreg_wr.en) begin
            wr_pulses++;
        end
        if (mem_req.req) begin
            req_cycles++;
        end
    end

    task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_vreg(string name, logic [`LSU_VREG_W-1:0] exp,
                              logic [`LSU_VREG_W-1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
        end
    endtask

    // a group byte is live when its element is below vl and, if masked, set in v0
    function automatic logic byte_live(row_t r, int pos);
        int elem;
        elem = pos >> int'(r.op.eew);
        return (elem < int'(r.vl)) && (!r.op.masked || r.v0[elem]);
    endfunction

    function automatic row_t make_row(logic store, eew_e eew, logic masked, lmul_e lmul,
                                      int vl, int base, int vd, logic [`LSU_VREG_W-1:0] v0_val);
        row_t r;
        r.op         = '{store: store, eew: eew, masked: masked};
        r.lmul       = lmul;
        r.vl         = `LSU_VL_W'(vl);
        r.base       = 32'(base);
        r.vd         = 5'(vd);
        r.v0         = v0_val;
        r.misaligned = (base % 4) != 0;
        return r;
    endfunction

    initial begin
        row_t r;
        int   regs;
        int   a;
        void'($urandom(7));
        rst_n  <= 1'b0;
        op_rdy <= 1'b0;
        op     <= '0;
        cfg    <= '0;
        v0     <= '0;
        env.init_mem();
        env.init_rf();
        rows[0]  = make_row(0, EEW_8,  0, LMUL_1, 16, 'h00, 4, '0);
        rows[1]  = make_row(0, EEW_16, 0, LMUL_1, 8, 'h20, 5, '0);
        rows[2]  = make_row(0, EEW_32, 0, LMUL_1, 4, 'h44, 6, '0);
        rows[3]  = make_row(0, EEW_8,  0, LMUL_2, 32, 'h10, 8, '0);
        rows[4]  = make_row(0, EEW_32, 0, LMUL_8, 32, 'h00, 16, '0);
        rows[5]  = make_row(0, EEW_8,  0, LMUL_4, 37, 'h40, 24, '0);
        rows[6]  = make_row(0, EEW_16, 1, LMUL_2, 16, 'h08, 10, {4{32'h9c3a_65d1}});
        rows[7]  = make_row(1, EEW_8,  0, LMUL_1, 16, 'h80, 4, '0);
        rows[8]  = make_row(1, EEW_32, 1, LMUL_4, 13, 'h90, 16, {4{32'h0000_1b6d}});
        rows[9]  = make_row(1, EEW_16, 0, LMUL_2, 11, 'hc0, 8, '0);
        rows[10] = make_row(0, EEW_8,  0, LMUL_1, 16, 'h22, 12, '0);
        rows[11] = make_row(1, EEW_8,  0, LMUL_2, 32, 'h81, 8, '0);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            r    = rows[i];
            regs = 1 << int'(r.lmul);
            exp_mem = env.mem;
            exp_rf  = env.rf;
            for (int pos = 0; pos < regs * 16 && !r.misaligned; pos++) begin
                a = (int'(r.base) + pos) % 256;
                if (byte_live(r, pos) && r.op.store) begin
                    exp_mem[a] = env.rf[r.vd + pos / 16][(pos % 16) * 8 +: 8];
                end else if (byte_live(r, pos)) begin
                    exp_rf[r.vd + pos / 16][(pos % 16) * 8 +: 8] = env.mem[a];
                end
            end

            @(posedge clk);
            wr_pulses  = 0;
            req_cycles = 0;
            op_rdy <= 1'b1;
            op     <= r.op;
            cfg    <= '{lmul: r.lmul, vl: r.vl, base_addr: r.base, vd: r.vd};
            v0     <= r.v0;
            @(negedge clk);
            check_flag($sformatf("row %0d op_ack", i), 1'b1, op_ack);
            check_flag($sformatf("row %0d misaligned", i), r.misaligned, misaligned);
            @(posedge clk);
            op_rdy <= 1'b0;
            @(negedge clk);
            // an accepted operation raises the flag of its own kind only
            check_flag($sformatf("row %0d pending_load busy", i),
                       !r.misaligned && !r.op.store, pending_load);
            check_flag($sformatf("row %0d pending_store busy", i),
                       !r.misaligned && r.op.store, pending_store);
            while (pending_load || pending_store) begin
                @(negedge clk);
            end
            // let the final register write land
            @(negedge clk);
            @(negedge clk);

            check_flag($sformatf("row %0d pending_load idle", i), 1'b0, pending_load);
            check_flag($sformatf("row %0d pending_store idle", i), 1'b0, pending_store);
            check_flag($sformatf("row %0d memory request", i), !r.misaligned, req_cycles != 0);
            check_byte($sformatf("row %0d vreg write pulses", i),
                       8'((r.misaligned || r.op.store) ? 0 : regs), 8'(wr_pulses));
            for (int m = 0; m < 256; m++) begin
                check_byte($sformatf("row %0d mem[%0d]", i, m), exp_mem[m], env.mem[m]);
            end
            for (int v = 0; v < 32; v++) begin
                check_vreg($sformatf("row %0d v%0d", i, v), exp_rf[v], env.rf[v]);
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- lsu_top.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_ctrl.sv
rtl/lsu_beat_counter.sv
rtl/lsu_req_path.sv
rtl/lsu_load_path.sv
rtl/lsu_top.sv
verif/tb_lsu_env.sv
verif/tb_lsu_top.sv

//--- Makefile
# Verilator build and run of the vector load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
RTL_TOP   ?= lsu_top
FILELIST  ?= lsu_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test OK

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
